/* rtl/uncache_params.svh */
// ==========================================================
// width and depth macros for the uncached access unit
// widths are fixed at 32-bit address and data, 4 byte lanes
// store depth must be a power of two, 2 or more
// ==========================================================
`ifndef UNCACHE_PARAMS_SVH
`define UNCACHE_PARAMS_SVH

// pipeline and bus address width
`define UC_ADDR_W 32

// one data word
`define UC_DATA_W 32

// byte strobe, one bit per lane of UC_DATA_W
`define UC_STRB_W 4

// store buffer entries
// kept small so a short burst of stores fills it
`define UC_STORE_DEPTH 4

`endif

/* rtl/uncache_pkg.sv */
// ==========================================================
// shared types of the uncached access unit
// widths come from the params header
// ==========================================================
`include "uncache_params.svh"

package uncache_pkg;

    // one store buffer entry, address on top
    typedef struct packed {
        logic [`UC_ADDR_W-1:0] addr;  // byte address as issued
        logic [`UC_DATA_W-1:0] data;  // write word
        logic [`UC_STRB_W-1:0] wstrb; // byte lanes to write
    } uc_store_t;

    // read sequencer
    typedef enum logic [1:0] {
        UC_RD_IDLE      = 2'd0, // no load pending
        UC_RD_WAIT_BUS  = 2'd1, // waiting for empty buffer and rd_rdy
        UC_RD_WAIT_DATA = 2'd2, // request taken, ret_valid pending
        UC_RD_DONE      = 2'd3  // word held until pipeline moves
    } uc_rd_state_t;

endpackage

/* rtl/store_fifo.sv */
// ==========================================================
// first-word-fall-through store buffer
// head is valid whenever empty is low, no read latency
// DEPTH must be a power of two, 2 or more
// push while full and pop while empty are not allowed
// ==========================================================
`timescale 1ns/1ns
`include "uncache_params.svh"

module store_fifo
    import uncache_pkg::*;
#(
    parameter int unsigned DEPTH = `UC_STORE_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  uc_store_t push_entry,
    input  logic      pop,
    output uc_store_t head,
    output logic      full,
    output logic      empty
);

    localparam int unsigned PTR_W = $clog2(DEPTH);

    uc_store_t          mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;    // one extra bit to tell full from empty
    logic               do_push;
    logic               do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign head  = mem[rd_ptr];                 // fall-through read
    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !push);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        empty |-> !pop);

endmodule

/* rtl/uncache_req_stage.sv */
// ==========================================================
// request register between pipeline and uncached bus side
// pipeline must keep cpu_stall high while busy is high
// a store leaves the register at the next unstalled edge
// busy covers an outstanding load and a full store buffer
// ==========================================================
`timescale 1ns/1ns
`include "uncache_params.svh"

module uncache_req_stage
    import uncache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_valid,
    input  logic                  cpu_op,     // 1 = store
    input  logic [`UC_ADDR_W-1:0] cpu_addr,
    input  logic [`UC_STRB_W-1:0] cpu_wstrb,
    input  logic [`UC_DATA_W-1:0] cpu_wdata,
    input  logic                  cpu_stall,
    input  logic                  full,
    input  logic                  rd_busy,
    output logic                  push,
    output uc_store_t             push_entry,
    output logic                  req_load,
    output logic                  busy
);

    logic                  req_valid;
    logic                  req_op;
    logic [`UC_ADDR_W-1:0] req_addr;
    logic [`UC_STRB_W-1:0] req_wstrb;
    logic [`UC_DATA_W-1:0] req_wdata;
    logic                  req_store;

    // control half, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            req_op    <= 1'b0;
        end else if (!cpu_stall) begin
            req_valid <= cpu_valid;
            req_op    <= cpu_op;
        end
    end

    // payload half
    always_ff @(posedge clk) begin
        if (!cpu_stall) begin
            req_addr  <= cpu_addr;
            req_wstrb <= cpu_wstrb;
            req_wdata <= cpu_wdata;
        end
    end

    assign req_store = req_valid & req_op;

    // store goes to the buffer as the register is overwritten
    assign push = req_store & ~cpu_stall & ~full;

    assign push_entry.addr  = req_addr;
    assign push_entry.data  = req_wdata;
    assign push_entry.wstrb = req_wstrb;

    // load accepted this edge, sequencer starts at the same edge
    assign req_load = cpu_valid & ~cpu_op & ~cpu_stall;

    assign busy = rd_busy | full; // load in flight or no room

    // a store must never be overwritten while the buffer has no room
    a_store_not_lost: assert property (@(posedge clk) disable iff (rst)
        (req_store && !cpu_stall) |-> !full);

    // pipeline contract
    a_stall_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> cpu_stall);

endmodule

/* rtl/uncache_bus_ctrl.sv */
// ==========================================================
// bus side of the uncached unit
// read sequencer runs one load at a time
// loads wait for the store buffer to drain before rd_req
// stores drain from the buffer head whenever wr_rdy is high
// rdata reads 0 outside the done state
// ==========================================================
`timescale 1ns/1ns
`include "uncache_params.svh"

module uncache_bus_ctrl
    import uncache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_load,
    input  logic                  cpu_stall,
    input  logic [`UC_ADDR_W-1:0] req_addr,
    input  uc_store_t             head,
    input  logic                  empty,
    output logic                  pop,
    output logic                  rd_req,
    output logic [`UC_ADDR_W-1:0] rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic [`UC_DATA_W-1:0] ret_data,
    output logic                  wr_req,
    output logic [`UC_ADDR_W-1:0] wr_addr,
    output logic [`UC_DATA_W-1:0] wr_data,
    output logic [`UC_STRB_W-1:0] wr_wstrb,
    input  logic                  wr_rdy,
    output logic                  rd_busy,
    output logic [`UC_DATA_W-1:0] rdata
);

    uc_rd_state_t          rd_state;
    uc_rd_state_t          rd_state_next;
    logic [`UC_DATA_W-1:0] rdata_q;
    logic                  rd_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= UC_RD_IDLE;
        end else begin
            rd_state <= rd_state_next;
        end
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            UC_RD_IDLE: begin
                if (req_load) rd_state_next = UC_RD_WAIT_BUS;
            end
            UC_RD_WAIT_BUS: begin
                if (rd_req && rd_rdy) rd_state_next = UC_RD_WAIT_DATA; // bus took it
            end
            UC_RD_WAIT_DATA: begin
                if (ret_valid) rd_state_next = UC_RD_DONE;
            end
            UC_RD_DONE: begin
                // hold the word until the pipeline moves on
                if (!cpu_stall) begin
                    rd_state_next = req_load ? UC_RD_WAIT_BUS : UC_RD_IDLE;
                end
            end
            default: rd_state_next = UC_RD_IDLE;
        endcase
    end

    // returned word taken in WAIT_DATA only
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            rdata_q <= ret_data;
        end
    end

    // no read until older stores have left the buffer
    assign rd_req  = (rd_state == UC_RD_WAIT_BUS) & empty;
    assign rd_addr = req_addr; // register holds while busy

    assign rd_busy = (rd_state == UC_RD_WAIT_BUS) | (rd_state == UC_RD_WAIT_DATA);
    assign rd_done = (rd_state == UC_RD_DONE);
    assign rdata   = rd_done ? rdata_q : '0;

    // write channel is the buffer head
    assign wr_req   = ~empty;
    assign wr_addr  = head.addr;
    assign wr_data  = head.data;
    assign wr_wstrb = head.wstrb;
    assign pop      = wr_req & wr_rdy;

    // data only comes back for a request the bus accepted
    a_ret_in_wait: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (rd_state == UC_RD_WAIT_DATA));

    // address held while the request waits for rd_rdy
    a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (rd_req && !rd_rdy) |=> $stable(rd_addr));

endmodule

/* rtl/uncache_unit.sv */
// ==========================================================
// uncached access unit, top level
// every access is uncached; stores queue, loads block
// pipeline holds cpu_stall high while busy is high
// ==========================================================
`timescale 1ns/1ns
`include "uncache_params.svh"

module uncache_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_valid,
    input  logic                  cpu_op,
    input  logic [`UC_ADDR_W-1:0] cpu_addr,
    input  logic [`UC_DATA_W-1:0] cpu_wdata,
    input  logic [`UC_STRB_W-1:0] cpu_wstrb,
    input  logic                  cpu_stall,
    output logic                  busy,
    output logic [`UC_DATA_W-1:0] rdata,
    output logic                  rd_req,
    output logic [`UC_ADDR_W-1:0] rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic [`UC_DATA_W-1:0] ret_data,
    output logic                  wr_req,
    output logic [`UC_ADDR_W-1:0] wr_addr,
    output logic [`UC_DATA_W-1:0] wr_data,
    output logic [`UC_STRB_W-1:0] wr_wstrb,
    input  logic                  wr_rdy
);

    localparam int STORE_W = `UC_ADDR_W + `UC_DATA_W + `UC_STRB_W; // one buffer entry

    logic               push;
    logic [STORE_W-1:0] push_entry;
    logic [STORE_W-1:0] head;
    logic               pop;
    logic               full;
    logic               empty;
    logic               req_load;
    logic               rd_busy;

    uncache_req_stage u_req_stage (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_op     (cpu_op),
        .cpu_addr   (cpu_addr),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_wdata  (cpu_wdata),
        .cpu_stall  (cpu_stall),
        .full       (full),
        .rd_busy    (rd_busy),
        .push       (push),
        .push_entry (push_entry),
        .req_load   (req_load),
        .busy       (busy)
    );

    store_fifo #(
        .DEPTH (`UC_STORE_DEPTH)
    ) u_store_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .full       (full),
        .empty      (empty)
    );

    // address field sits on top of the entry
    uncache_bus_ctrl u_bus_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_load  (req_load),
        .cpu_stall (cpu_stall),
        .req_addr  (push_entry[STORE_W-1 -: `UC_ADDR_W]),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_wstrb  (wr_wstrb),
        .wr_rdy    (wr_rdy),
        .rd_busy   (rd_busy),
        .rdata     (rdata)
    );

endmodule

/* verif/tb_uncache_unit.sv */
// ==========================================================
// testbench for the uncached access unit
// accesses and expected words come from verif/uncache_stim.txt
// run from the project root so that path resolves
// bus memory model holds 64 words, byte addresses below 0x100
// rd_rdy and wr_rdy are random from a fixed seed
// ==========================================================
`timescale 1ns/1ns
`include "uncache_params.svh"

module tb_uncache_unit
    import uncache_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cpu_valid;
    logic                  cpu_op;
    logic [`UC_ADDR_W-1:0] cpu_addr;
    logic [`UC_DATA_W-1:0] cpu_wdata;
    logic [`UC_STRB_W-1:0] cpu_wstrb;
    logic                  cpu_stall;
    logic                  busy;
    logic [`UC_DATA_W-1:0] rdata;
    logic                  rd_req;
    logic [`UC_ADDR_W-1:0] rd_addr;
    logic                  rd_rdy = 1'b0;
    logic                  ret_valid = 1'b0;
    logic [`UC_DATA_W-1:0] ret_data = '0;
    logic                  wr_req;
    logic [`UC_ADDR_W-1:0] wr_addr;
    logic [`UC_DATA_W-1:0] wr_data;
    logic [`UC_STRB_W-1:0] wr_wstrb;
    logic                  wr_rdy = 1'b0;

    integer                seed = 32'h09010270;
    int unsigned           cycle_count = 0;
    int unsigned           cycle_limit = 0;   // set once the stimulus is read
    int unsigned           wr_hold_until = 0; // wr_rdy forced low before this cycle
    logic [`UC_DATA_W-1:0] mem [64];          // word index is addr[7:2]
    uc_store_t             exp_stores [$];    // issue order
    logic [`UC_ADDR_W-1:0] load_addr = '0;    // address of the load in flight
    logic [31:0]           st_op [$];
    logic [31:0]           st_addr [$];
    logic [31:0]           st_strb [$];
    logic [31:0]           st_data [$];
    logic [31:0]           st_exp [$];
    logic [31:0]           st_extra [$];
    logic                  store_full_seen = 1'b0;
    logic                  wr_take = 1'b0;    // bus transfers at the coming edge
    logic                  rd_take = 1'b0;
    logic [5:0]            rd_idx = '0;
    logic                  ret_pend = 1'b0;
    logic [1:0]            ret_cnt = '0;
    logic [`UC_DATA_W-1:0] ret_word = '0;

    uncache_unit DUT (.*);

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [`UC_DATA_W-1:0] got,
                              input logic [`UC_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [`UC_ADDR_W-1:0] got,
                              input logic [`UC_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_store(input uc_store_t got, input uc_store_t exp);
        if (got !== exp) begin
            $display("FAIL wr_addr/wr_data/wr_wstrb got %h/%h/%h expected %h/%h/%h",
                     got.addr, got.data, got.wstrb, exp.addr, exp.data, exp.wstrb);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // upper half of the byte address kept and lower half inverted
    function automatic logic [`UC_DATA_W-1:0] fill_word(input int unsigned widx);
        logic [`UC_ADDR_W-1:0] baddr;
        baddr = `UC_ADDR_W'(widx) << 2;
        return {baddr[31:16], ~baddr[15:0]};
    endfunction

    task automatic read_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [6];
        fd = $fopen("verif/uncache_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verif/uncache_stim.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line.substr(0, 1) == "//") continue; // column notes
            n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            if (n == 6) begin
                st_op.push_back(f[0]);
                st_addr.push_back(f[1]);
                st_strb.push_back(f[2]);
                st_data.push_back(f[3]);
                st_exp.push_back(f[4]);
                st_extra.push_back(f[5]);
            end
        end
        $fclose(fd);
        if (st_op.size() == 0) begin
            $display("the stimulus file holds no accesses");
            abort_run();
        end
    endtask

    // polled mid-cycle since busy only moves at rising edges
    task automatic wait_not_busy();
        @(negedge clk);
        while (busy) begin
            store_full_seen = 1'b1; // with no load open only a full buffer raises busy
            @(negedge clk);
        end
    endtask

    task automatic check_load(input logic [`UC_DATA_W-1:0] exp, input logic [31:0] extra);
        @(negedge clk);
        while (busy) @(negedge clk); // busy falls once the word is back
        check_word("rdata", rdata, exp);
        repeat (extra) begin
            @(negedge clk);
            check_word("rdata", rdata, exp); // held under extra stall
        end
    endtask

    // one access is a single unstalled cycle and then stall until done
    task automatic run_access(input int i);
        uc_store_t entry;
        wait_not_busy();
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_op    <= st_op[i][0];
        cpu_addr  <= st_addr[i];
        cpu_wstrb <= st_strb[i][`UC_STRB_W-1:0];
        cpu_wdata <= st_data[i];
        cpu_stall <= 1'b0;
        if (st_op[i][0]) begin
            entry.addr  = st_addr[i];
            entry.data  = st_data[i];
            entry.wstrb = st_strb[i][`UC_STRB_W-1:0];
            exp_stores.push_back(entry);
            if (st_extra[i] != 0) wr_hold_until <= cycle_count + st_extra[i];
        end else begin
            load_addr = st_addr[i];
        end
        @(posedge clk); // DUT takes the access here
        cpu_valid <= 1'b0;
        cpu_stall <= 1'b1;
        if (!st_op[i][0]) check_load(st_exp[i], st_extra[i]);
    endtask

    // write channel check and memory update
    task automatic take_bus_write();
        uc_store_t got;
        uc_store_t exp;
        logic [5:0] idx;
        got.addr  = wr_addr;
        got.data  = wr_data;
        got.wstrb = wr_wstrb;
        if (exp_stores.size() == 0) begin
            $display("a store reached the write channel with none outstanding");
            abort_run();
        end
        exp = exp_stores.pop_front();
        check_store(got, exp);
        idx = wr_addr[7:2];
        for (int b = 0; b < `UC_STRB_W; b++) begin
            if (wr_wstrb[b]) mem[idx][8*b +: 8] = wr_data[8*b +: 8];
        end
    endtask

    // bus decisions mid-cycle when outputs have settled
    always @(negedge clk) begin
        wr_take = !rst && wr_req && wr_rdy;
        rd_take = !rst && rd_req && rd_rdy;
        rd_idx  = rd_addr[7:2];
        if (!rst && rd_req && wr_req) begin
            $display("a read was requested while stores were still queued for the bus");
            abort_run();
        end
        if (rd_take) check_addr("rd_addr", rd_addr, load_addr);
        if (wr_take) take_bus_write();
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_pend  <= 1'b0;
        end else begin
            rd_rdy <= ($random(seed) & 3) != 0; // ready about 3 in 4
            if (cycle_count < wr_hold_until) wr_rdy <= 1'b0;
            else wr_rdy <= ($random(seed) & 3) != 0;
            ret_valid <= 1'b0;
            if (rd_take) begin
                ret_pend <= 1'b1;
                ret_cnt  <= 2'($random(seed)); // 1 to 4 cycles to ret_valid
                ret_word <= mem[rd_idx];
            end else if (ret_pend) begin
                if (ret_cnt == 0) begin
                    ret_valid <= 1'b1;
                    ret_data  <= ret_word;
                    ret_pend  <= 1'b0;
                end else begin
                    ret_cnt <= ret_cnt - 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            abort_run();
        end
    end

    initial begin
        rst       = 1'b1;
        cpu_valid = 1'b0;
        cpu_op    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        cpu_stall = 1'b1; // parked between accesses
        for (int a = 0; a < 64; a++) mem[a] = fill_word(a);
        read_stim();
        cycle_limit = 40 * st_op.size() + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("rd_req", rd_req, 1'b0);
        check_flag("wr_req", wr_req, 1'b0);
        for (int i = 0; i < st_op.size(); i++) run_access(i);
        // idle unstalled cycle pushes a store left in the request register
        wait_not_busy();
        @(posedge clk);
        cpu_stall <= 1'b0;
        @(posedge clk);
        cpu_stall <= 1'b1;
        while (exp_stores.size() != 0) @(negedge clk);
        @(negedge clk);
        check_flag("wr_req", wr_req, 1'b0);
        check_flag("busy", store_full_seen, 1'b1); // full buffer was reached
        $display("Done: no errors");
        $finish;
    end

endmodule

/* verif/uncache_stim.txt */
// op addr strb wdata expect extra, all hex, one access per line, op 1 = store
// extra is stall cycles after a load, or write channel hold cycles for a store
// loads from untouched words, fill is {addr[31:16], ~addr[15:0]}
0 00000000 0 00000000 0000ffff 0
0 00000040 0 00000000 0000ffbf 0
0 000000fc 0 00000000 0000ff03 1
0 00000014 0 00000000 0000ffeb 3
// full-word stores, then reads back
1 00000080 f 11223344 00000000 0
1 00000084 f 55667788 00000000 0
1 00000088 f 99aabbcc 00000000 0
0 00000084 0 00000000 55667788 0
0 00000080 0 00000000 11223344 2
// byte lanes merged into word 0x20, fill 0000ffdf
1 00000020 1 aaaaaa11 00000000 0
1 00000020 4 bbccbbbb 00000000 0
1 00000020 8 dd000000 00000000 0
0 00000020 0 00000000 ddccff11 2
// middle lanes of word 0x30, fill 0000ffcf
1 00000030 6 12345678 00000000 0
0 00000030 0 00000000 003456cf 0
// low half of word 0x10, fill 0000ffef
1 00000010 3 ffff1234 00000000 0
0 00000010 0 00000000 00001234 1
// six stores with the write channel held off for 0x30 cycles
1 000000c0 f c0c0c0c0 00000000 30
1 000000c4 f c4c4c4c4 00000000 0
1 000000c8 f c8c8c8c8 00000000 0
1 000000cc f cccccccc 00000000 0
1 000000d0 f d0d0d0d0 00000000 0
1 000000d4 f d4d4d4d4 00000000 0
0 000000d4 0 00000000 d4d4d4d4 0
0 000000c0 0 00000000 c0c0c0c0 4
0 000000cc 0 00000000 cccccccc 0
// upper lanes over an earlier store, read right after
1 00000088 c 77660000 00000000 0
0 00000088 0 00000000 7766bbcc 0
0 000000e0 0 00000000 0000ff1f 2

/* sources.f */
+incdir+rtl
rtl/uncache_pkg.sv
rtl/store_fifo.sv
rtl/uncache_req_stage.sv
rtl/uncache_bus_ctrl.sv
rtl/uncache_unit.sv
verif/tb_uncache_unit.sv

/* Makefile */
# Verilator build and run of the uncached unit testbench
# the run exits non-zero when the testbench stops on an error

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_uncache_unit -o sim_uncache
	./obj_dir/sim_uncache

clean:
	rm -rf obj_dir
